/* hw/rx_macros.svh */
// widths, control characters and link timing for the rx mac, included by the package and RTL
`ifndef RX_MACROS_SVH
`define RX_MACROS_SVH

// bus geometry
`define RX_LANES        32  // byte lanes per word
`define RX_DATA_W       256
`define RX_START_LANES  8   // a start may only sit on every fourth byte

// control characters, valid only with the lane's ctrl bit set
`define RX_CHAR_START   8'hfb
`define RX_CHAR_TERM    8'hfd
`define RX_CHAR_SEQ     8'h9c  // fault ordered set
`define RX_CHAR_IDLE    8'h07

// fault-free cycles spent in recovery before the link is declared good
`define RX_LINK_WAIT    8

`endif

/* hw/rx_pkg.sv */
// shared bus, event, speed and byte-count types for the rx mac, imported by the RTL and testbench
`default_nettype none
`include "rx_macros.svh"

package rx_pkg;

	// one word from the PCS, ctrl bit n flags byte lane n as a control character
	typedef struct packed {
		logic [`RX_DATA_W-1:0] data;
		logic [`RX_LANES-1:0]  ctrl;
	} rx_word_t;

	// hold time per word is 4 clocks at 25G, 2 at 40G and 50G
	typedef enum logic [1:0] {
		SPEED_25G = 2'd0,
		SPEED_40G = 2'd1,
		SPEED_50G = 2'd2
	} rx_speed_t;

	// delimiter events of one cycle, aligned with the delayed word
	typedef struct packed {
		logic       sof;
		logic [2:0] sof_lane;  // start position, byte 4*sof_lane
		logic       eof;
		logic [4:0] eof_lane;  // byte lane of the terminate
		logic       in_frame;
	} rx_evt_t;

	// byte-count word as written to the count FIFO
	typedef struct packed {
		logic [7:0]  sof_mark;   // one-hot start position
		logic        same_word;  // start and terminate in one word
		logic [6:0]  rsvd;
		logic [15:0] bytes;
	} rx_bcnt_t;

endpackage

`default_nettype wire

/* hw/rx_stage_reg.sv */
// register with load enable and reset value, typed by parameter for bus words and count words
`default_nettype none

module rx_stage_reg #(
	parameter type      payload_t = logic [31:0],
	parameter payload_t RESET_VAL = '0
) (
	input  wire      clk,
	input  wire      reset_,
	input  wire      load,
	input  wire      payload_t d,
	output payload_t q
);

	// holds its value until the next load
	always_ff @(posedge clk) begin
		if (!reset_) begin
			q <= RESET_VAL;
		end else if (load) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

/* hw/rx_link_fsm.sv */
// link monitor, watches init_done and fault ordered sets on the delayed word and drives linkup
`default_nettype none
`include "rx_macros.svh"

module rx_link_fsm (
	input  wire              clk,
	input  wire              reset_,
	input  wire              init_done,
	input  wire rx_pkg::rx_word_t rx_dly,
	output logic             linkup
);

	localparam int CNT_W = $clog2(`RX_LINK_WAIT + 1);

	typedef enum logic [2:0] {
		LINK_FAIL = 3'b001,
		LINK_RCVR = 3'b010,
		LINK_GOOD = 3'b100
	} link_state_t;

	link_state_t                state;
	logic [CNT_W-1:0]           wait_cnt;
	logic [`RX_START_LANES-1:0] seq_found;
	logic                       fault;
	logic                       fault_q;

	// ordered sets only start on the four-byte positions
	always_comb begin
		for (int k = 0; k < `RX_START_LANES; k++)
			seq_found[k] = rx_dly.ctrl[4*k] && (rx_dly.data[32*k +: 8] == `RX_CHAR_SEQ);
	end

	assign fault = !init_done || (|seq_found);

	always_ff @(posedge clk) begin
		if (!reset_) begin
			fault_q  <= 1'b1;
			state    <= LINK_FAIL;
			wait_cnt <= CNT_W'(`RX_LINK_WAIT);
		end else begin
			fault_q <= fault;
			case (state)
				LINK_FAIL: begin
					wait_cnt <= CNT_W'(`RX_LINK_WAIT);  // rearm for the next recovery
					if (!fault_q)
						state <= LINK_RCVR;
				end
				LINK_RCVR: begin
					if (fault_q)
						state <= LINK_FAIL;
					else if (wait_cnt == '0)
						state <= LINK_GOOD;
					else
						wait_cnt <= wait_cnt - 1'b1;
				end
				LINK_GOOD: begin
					if (fault_q)
						state <= LINK_FAIL;
				end
				default: state <= LINK_FAIL;
			endcase
		end
	end

	assign linkup = (state == LINK_GOOD);  // decoded straight from the state flops

endmodule

`default_nettype wire

/* hw/rx_beat_counter.sv */
// beat counter for the held bus words, aligns on frame start and makes the one-per-word write strobe
`default_nettype none

module rx_beat_counter (
	input  wire               clk,
	input  wire               reset_,
	input  wire rx_pkg::rx_speed_t speed,
	input  wire rx_pkg::rx_evt_t   evt,
	output logic              beat_first,
	output logic              word_we
);
	import rx_pkg::*;

	logic [1:0] count;  // beat of the word currently at rx_in
	logic [1:0] beat;
	logic [1:0] last;

	assign last = (speed == SPEED_25G) ? 2'd3 : 2'd1;

	// sof surfaces one cycle late, so the start word is on its second
	// input beat by then; the count restarts from that word's beat zero
	assign beat = evt.sof ? 2'd1 : count;
	assign beat_first = (beat == 2'd0);

	always_ff @(posedge clk) begin
		if (!reset_) begin
			count   <= 2'd0;
			word_we <= 1'b0;
		end else begin
			count <= (beat == last) ? 2'd0 : beat + 2'd1;
			// input beat 1 is beat 0 of the delayed word
			word_we <= (beat == 2'd1) && (evt.in_frame || evt.eof);
		end
	end

endmodule

`default_nettype wire

/* hw/rx_delim_detect.sv */
// start and terminate finder on the raw input word, registers the events next to the delayed word
`default_nettype none
`include "rx_macros.svh"

module rx_delim_detect (
	input  wire              clk,
	input  wire              reset_,
	input  wire rx_pkg::rx_word_t rx_in,
	input  wire              beat_first,
	output rx_pkg::rx_evt_t  evt
);

	logic [`RX_START_LANES-1:0] start_found;
	logic [`RX_LANES-1:0]       term_found;
	logic                       start_any;
	logic [2:0]                 start_pos;
	logic                       term_any;
	logic [4:0]                 term_lane;
	logic                       in_frame;
	logic                       closed;  // frame ended, its word still on the bus
	logic                       sof_hit;
	logic                       eof_hit;
	logic                       sof_q;
	logic                       eof_q;
	logic [2:0]                 sof_lane_q;
	logic [4:0]                 eof_lane_q;

	always_comb begin
		for (int k = 0; k < `RX_START_LANES; k++)
			start_found[k] = rx_in.ctrl[4*k] && (rx_in.data[32*k +: 8] == `RX_CHAR_START);
		for (int l = 0; l < `RX_LANES; l++)
			term_found[l] = rx_in.ctrl[l] && (rx_in.data[8*l +: 8] == `RX_CHAR_TERM);
	end

	// lowest start position wins
	always_comb begin
		start_any = 1'b0;
		start_pos = 3'd0;
		for (int k = `RX_START_LANES - 1; k >= 0; k--) begin
			if (start_found[k]) begin
				start_any = 1'b1;
				start_pos = 3'(k);
			end
		end
	end

	// lowest terminate lane, and in a start word only lanes past the start
	always_comb begin
		term_any  = 1'b0;
		term_lane = 5'd0;
		for (int l = `RX_LANES - 1; l >= 0; l--) begin
			if (term_found[l] && (in_frame || l > 4 * start_pos)) begin
				term_any  = 1'b1;
				term_lane = 5'(l);
			end
		end
	end

	// a closed word may hold its start again on the later beats, so
	// wait for the next word before looking for a new frame
	assign sof_hit = start_any && !in_frame && (!closed || beat_first);
	assign eof_hit = term_any && ((in_frame && beat_first) || sof_hit);

	always_ff @(posedge clk) begin
		if (!reset_) begin
			in_frame <= 1'b0;
			closed   <= 1'b0;
			sof_q    <= 1'b0;
			eof_q    <= 1'b0;
		end else begin
			if (eof_hit)
				in_frame <= 1'b0;
			else if (sof_hit)
				in_frame <= 1'b1;
			closed <= eof_hit || (closed && !beat_first);
			sof_q  <= sof_hit;
			eof_q  <= eof_hit;
		end
	end

	// lane numbers only matter next to their strobe
	always_ff @(posedge clk) begin
		sof_lane_q <= start_pos;
		eof_lane_q <= term_lane;
	end

	assign evt = '{
		sof:      sof_q,
		sof_lane: sof_lane_q,
		eof:      eof_q,
		eof_lane: eof_lane_q,
		in_frame: in_frame
	};

endmodule

`default_nettype wire

/* hw/rx_byte_count.sv */
// per-frame byte accumulator, builds the count word with start marker and same-word flag
`default_nettype none
`include "rx_macros.svh"

module rx_byte_count (
	input  wire              clk,
	input  wire              reset_,
	input  wire rx_pkg::rx_evt_t evt,
	input  wire              word_we,
	output rx_pkg::rx_bcnt_t bcnt_next,
	output logic             done
);

	logic [15:0]                acc;
	logic [15:0]                start_off;   // byte offset of the start character
	logic [15:0]                term_bytes;  // bytes through the terminate lane
	logic [`RX_START_LANES-1:0] sof_mark;
	logic                       same_word;
	logic                       skip_we;     // strobe of a start or terminate word

	assign start_off  = 16'({evt.sof_lane, 2'b00});
	assign term_bytes = 16'(evt.eof_lane) + 16'd1;

	// the strobe for a word trails its event by one cycle, so the start
	// and terminate words must not be counted a second time
	always_ff @(posedge clk) begin
		if (!reset_) begin
			done    <= 1'b0;
			skip_we <= 1'b0;
		end else begin
			done    <= evt.eof;
			skip_we <= evt.sof || evt.eof;
		end
	end

	always_ff @(posedge clk) begin
		if (evt.sof && evt.eof)
			acc <= term_bytes - start_off;  // whole frame inside one word
		else if (evt.sof)
			acc <= 16'(`RX_LANES) - start_off;
		else if (evt.eof)
			acc <= acc + term_bytes;
		else if (word_we && !skip_we)
			acc <= acc + 16'(`RX_LANES);  // full middle word
	end

	always_ff @(posedge clk) begin
		if (evt.sof) begin
			sof_mark  <= `RX_START_LANES'(1) << evt.sof_lane;
			same_word <= evt.eof;
		end
	end

	assign bcnt_next = '{
		sof_mark:  sof_mark,
		same_word: same_word,
		rsvd:      7'd0,
		bytes:     acc
	};

endmodule

`default_nettype wire

/* hw/rx_mac_top.sv */
// rx mac top level, connects input/output stages, delimiter, beat, byte-count and link blocks
`default_nettype none
`include "rx_macros.svh"

module rx_mac_top (
	input  wire                clk,
	input  wire                reset_,
	input  wire rx_pkg::rx_speed_t speed,       // static while running
	input  wire                init_done,
	input  wire rx_pkg::rx_word_t  rx_in,
	output rx_pkg::rx_word_t   rx_out,
	output logic               x_we,
	output logic               x_bcnt_we,
	output rx_pkg::rx_bcnt_t   x_byte_cnt,
	output logic               linkup
);
	import rx_pkg::*;

	localparam rx_word_t IDLE_WORD = '{
		data: {`RX_LANES{`RX_CHAR_IDLE}},
		ctrl: {`RX_LANES{1'b1}}
	};

	rx_word_t rx_dly;     // input word one cycle late, lines up with evt
	rx_evt_t  evt;
	logic     beat_first;
	logic     word_we;
	logic     done;
	rx_bcnt_t bcnt_next;

	rx_stage_reg #(.payload_t(rx_word_t), .RESET_VAL(IDLE_WORD)) i_in_reg (
		.clk    (clk),
		.reset_ (reset_),
		.load   (1'b1),
		.d      (rx_in),
		.q      (rx_dly)
	);

	rx_delim_detect i_delim (
		.clk        (clk),
		.reset_     (reset_),
		.rx_in      (rx_in),
		.beat_first (beat_first),
		.evt        (evt)
	);

	rx_beat_counter i_beat (
		.clk        (clk),
		.reset_     (reset_),
		.speed      (speed),
		.evt        (evt),
		.beat_first (beat_first),
		.word_we    (word_we)
	);

	rx_stage_reg #(.payload_t(rx_word_t), .RESET_VAL(IDLE_WORD)) i_out_reg (
		.clk    (clk),
		.reset_ (reset_),
		.load   (word_we),
		.d      (rx_dly),
		.q      (rx_out)
	);

	rx_byte_count i_bcnt (
		.clk       (clk),
		.reset_    (reset_),
		.evt       (evt),
		.word_we   (word_we),
		.bcnt_next (bcnt_next),
		.done      (done)
	);

	rx_stage_reg #(.payload_t(rx_bcnt_t), .RESET_VAL('0)) i_bcnt_reg (
		.clk    (clk),
		.reset_ (reset_),
		.load   (done),
		.d      (bcnt_next),
		.q      (x_byte_cnt)
	);

	rx_link_fsm i_link (
		.clk       (clk),
		.reset_    (reset_),
		.init_done (init_done),
		.rx_dly    (rx_dly),
		.linkup    (linkup)
	);

	// strobes follow their stage registers by one cycle
	always_ff @(posedge clk) begin
		if (!reset_) begin
			x_we      <= 1'b0;
			x_bcnt_we <= 1'b0;
		end else begin
			x_we      <= word_we;
			x_bcnt_we <= done;
		end
	end

endmodule

`default_nettype wire

/* dv/rx_tb_clk.sv */
// clock and reset source for the rx mac testbench, period 10 with reset held low for 16 cycles
`default_nettype none

module rx_tb_clk #(
	parameter int HALF_PERIOD  = 5,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic reset_
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	initial begin
		reset_ = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);  // release away from the sampling edge
		reset_ = 1'b1;
	end

endmodule

`default_nettype wire

/* dv/rx_tb.sv */
// directed testbench for the rx mac, sends frames at each speed and checks words, counts and linkup
`default_nettype none
`include "rx_macros.svh"

module rx_tb;
	import rx_pkg::*;

	localparam int WAIT_LIMIT = 64;  // cycles allowed for any strobe

	logic      clk;
	logic      reset_;
	rx_speed_t speed;
	logic      init_done;
	rx_word_t  rx_in;
	rx_word_t  rx_out;
	logic      x_we;
	logic      x_bcnt_we;
	rx_bcnt_t  x_byte_cnt;
	logic      linkup;

	logic [31:0] lfsr;
	int          errors;
	int          checks;
	int          tests;
	rx_word_t    tx_q[$];  // words waiting to be sent
	rx_word_t    exp_words[$];
	rx_bcnt_t    exp_cnts[$];
	rx_word_t    got_words[$];
	rx_bcnt_t    got_cnts[$];

	rx_tb_clk i_clk (.clk(clk), .reset_(reset_));

	rx_mac_top i_dut (
		.clk        (clk),
		.reset_     (reset_),
		.speed      (speed),
		.init_done  (init_done),
		.rx_in      (rx_in),
		.rx_out     (rx_out),
		.x_we       (x_we),
		.x_bcnt_we  (x_bcnt_we),
		.x_byte_cnt (x_byte_cnt),
		.linkup     (linkup)
	);

	// capture strobed outputs on the falling edge, where they are settled
	always @(negedge clk) begin
		if (reset_ && x_we)
			got_words.push_back(rx_out);
		if (reset_ && x_bcnt_we)
			got_cnts.push_back(x_byte_cnt);
	end

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic logic [7:0] data_byte();
		logic [7:0] b;
		b = 8'(rand_bits(8));
		while (b == `RX_CHAR_START || b == `RX_CHAR_TERM || b == `RX_CHAR_SEQ
				|| b == `RX_CHAR_IDLE)
			b = 8'(rand_bits(8));
		return b;
	endfunction

	function automatic rx_word_t idle_word();
		rx_word_t w;
		w.data = {`RX_LANES{`RX_CHAR_IDLE}};
		w.ctrl = '1;
		return w;
	endfunction

	function automatic rx_word_t fault_word();
		rx_word_t w;
		w = idle_word();
		w.data[31:0] = {24'h0, `RX_CHAR_SEQ};  // ordered set on lane 0
		w.ctrl[3:0]  = 4'b0001;
		return w;
	endfunction

	task automatic check_eq(input string name, input logic [287:0] got, input logic [287:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input bit ok, input string what);
		checks++;
		assert (ok) else begin
			$display("Error at %0t: %s", $time, what);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int err0);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - err0);
	endtask

	task automatic send_word(input rx_word_t w, input int hold);
		@(negedge clk);
		rx_in = w;
		repeat (hold - 1) @(negedge clk);
	endtask

	task automatic wait_linkup(input logic level, input int limit, output bit ok);
		int n;
		n = 0;
		while (linkup !== level && n < limit) begin
			@(negedge clk);
			n++;
		end
		ok = (linkup === level);
	endtask

	task automatic wait_counts(input int want, output bit ok);
		int n;
		n = 0;
		while (got_cnts.size() < want && n < WAIT_LIMIT) begin
			@(posedge clk);  // queue only grows on the falling edge
			n++;
		end
		ok = (got_cnts.size() >= want);
	endtask

	task automatic add_idle(input int n);
		repeat (n) tx_q.push_back(idle_word());
	endtask

	// builds one frame and its expected count of bytes from start through terminate
	task automatic add_frame(input int pos, input int nwords, input int term);
		rx_word_t w;
		rx_bcnt_t c;
		bit       counting;
		int       nbytes;
		counting = 0;
		nbytes   = 0;
		for (int k = 0; k < nwords; k++) begin
			for (int l = 0; l < `RX_LANES; l++) begin
				if ((k == 0 && l < 4 * pos) || (k == nwords - 1 && l > term))
					{w.data[8*l +: 8], w.ctrl[l]} = {`RX_CHAR_IDLE, 1'b1};
				else if (k == 0 && l == 4 * pos)
					{w.data[8*l +: 8], w.ctrl[l]} = {`RX_CHAR_START, 1'b1};
				else if (k == nwords - 1 && l == term)
					{w.data[8*l +: 8], w.ctrl[l]} = {`RX_CHAR_TERM, 1'b1};
				else
					{w.data[8*l +: 8], w.ctrl[l]} = {data_byte(), 1'b0};
				if (w.ctrl[l] && w.data[8*l +: 8] == `RX_CHAR_START)
					counting = 1;
				if (counting)
					nbytes++;
				if (w.ctrl[l] && w.data[8*l +: 8] == `RX_CHAR_TERM)
					counting = 0;
			end
			tx_q.push_back(w);
			exp_words.push_back(w);
		end
		c.sof_mark  = 8'(1) << pos;
		c.same_word = (nwords == 1);
		c.rsvd      = '0;
		c.bytes     = 16'(nbytes);
		exp_cnts.push_back(c);
	endtask

	// sends the queued words, then compares every strobed word and count
	task automatic play_frames(input int hold);
		bit ok;
		@(posedge clk);
		got_words.delete();
		got_cnts.delete();
		add_idle(4);  // flush the pipeline
		while (tx_q.size() > 0)
			send_word(tx_q.pop_front(), hold);
		wait_counts(exp_cnts.size(), ok);
		check_true(ok, "timed out waiting for x_bcnt_we");
		check_eq("x_we pulse count", got_words.size(), exp_words.size());
		for (int i = 0; i < exp_words.size() && i < got_words.size(); i++)
			check_eq("rx_out", got_words[i], exp_words[i]);
		check_eq("x_bcnt_we pulse count", got_cnts.size(), exp_cnts.size());
		for (int i = 0; i < exp_cnts.size() && i < got_cnts.size(); i++) begin
			check_eq("x_byte_cnt.bytes", got_cnts[i].bytes, exp_cnts[i].bytes);
			check_eq("x_byte_cnt.sof_mark", got_cnts[i].sof_mark, exp_cnts[i].sof_mark);
			check_eq("x_byte_cnt.same_word", got_cnts[i].same_word, exp_cnts[i].same_word);
			check_eq("x_byte_cnt.rsvd", got_cnts[i].rsvd, exp_cnts[i].rsvd);
		end
		exp_words.delete();
		exp_cnts.delete();
		@(negedge clk);  // next test starts on the drive edge
	endtask

	task automatic link_checks();
		bit ok;
		bit stayed_low;
		int err0;
		err0 = errors;
		check_eq("linkup", linkup, 1'b0);  // state right after reset
		check_eq("x_we", x_we, 1'b0);
		check_eq("x_bcnt_we", x_bcnt_we, 1'b0);
		check_eq("x_byte_cnt", x_byte_cnt, '0);
		check_eq("rx_out", rx_out, idle_word());
		wait_linkup(1'b1, 16, ok);
		check_true(ok, "linkup did not rise within 16 cycles of reset");
		send_word(fault_word(), 2);
		send_word(idle_word(), 1);
		wait_linkup(1'b0, 2, ok);
		check_true(ok, "linkup did not drop within 4 cycles of a fault ordered set");
		wait_linkup(1'b1, 32, ok);
		check_true(ok, "linkup did not return after the fault cleared");
		@(negedge clk);
		init_done = 1'b0;
		wait_linkup(1'b0, 4, ok);
		check_true(ok, "linkup did not drop with init_done low");
		stayed_low = 1;
		repeat (20) begin
			@(negedge clk);
			stayed_low &= !linkup;
		end
		check_true(stayed_low, "linkup rose while init_done was low");
		init_done = 1'b1;
		wait_linkup(1'b1, 32, ok);
		check_true(ok, "linkup did not rise after init_done returned");
		finish_test("link up", err0);
	endtask

	task automatic long_frame_50g();
		int err0;
		err0 = errors;
		speed = SPEED_50G;
		add_idle(2);
		add_frame(0, 4, int'(rand_bits(5)));
		play_frames(2);
		finish_test("50G multi-word frame", err0);
	endtask

	task automatic starts_25g();
		int err0;
		err0 = errors;
		speed = SPEED_25G;
		add_idle(2);
		for (int pos = 1; pos < `RX_START_LANES; pos++) begin
			add_frame(pos, 2 + int'(rand_bits(1)), int'(rand_bits(5)));
			add_idle(2);
		end
		play_frames(4);
		finish_test("25G start positions", err0);
	endtask

	task automatic same_word_40g();
		int err0;
		err0 = errors;
		speed = SPEED_40G;
		add_idle(2);
		add_frame(0, 1, 1 + int'(rand_bits(5)) % 31);  // terminate past the start
		add_idle(2);
		add_frame(5, 1, 21 + int'(rand_bits(5)) % 11);
		play_frames(2);
		finish_test("40G same-word frames", err0);
	endtask

	task automatic back_to_back_50g();
		int err0;
		err0 = errors;
		speed = SPEED_50G;
		add_idle(2);
		add_frame(0, 3, int'(rand_bits(5)));
		add_idle(1);
		add_frame(3, 2, int'(rand_bits(5)));
		add_idle(1);
		add_frame(2, 1, 9 + int'(rand_bits(5)) % 23);
		play_frames(2);
		finish_test("50G back-to-back frames", err0);
	endtask

	initial begin
		int n;
		lfsr      = 32'h0b4332b2;
		errors    = 0;
		checks    = 0;
		tests     = 0;
		speed     = SPEED_50G;
		init_done = 1'b1;
		rx_in     = idle_word();
		n = 0;
		while (reset_ !== 1'b1 && n < 64) begin
			@(negedge clk);
			n++;
		end
		check_true(reset_ === 1'b1, "reset was never released");
		link_checks();
		long_frame_50g();
		starts_25g();
		same_word_40g();
		back_to_back_50g();
		$display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hw
hw/rx_pkg.sv
hw/rx_stage_reg.sv
hw/rx_link_fsm.sv
hw/rx_beat_counter.sv
hw/rx_delim_detect.sv
hw/rx_byte_count.sv
hw/rx_mac_top.sv
dv/rx_tb_clk.sv
dv/rx_tb.sv
